// File: mshr_assertions.sv
`timescale 1ns/1ps
`include "mshr_params.svh"

module mshr_assertions (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  grant_valid_i,
    input  mshr_pkg::entry_vec_t  req_i,
    input  mshr_pkg::entry_vec_t  memory_grant_i,
    input  mshr_pkg::mem_in_t     mem_req_i,
    input  mshr_pkg::mem_out_t    mem_resp_i
);

    // ==========================================================
    // Memory port rules
    // ==========================================================
    // At most one entry owns the port and it is requesting
    grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($onehot0(memory_grant_i) && ((memory_grant_i & ~req_i) == '0)))
        else $error("memory grant not one-hot or not on a requester: %b", memory_grant_i);

    // Port carries a command exactly while a grant is held
    idle_port: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (grant_valid_i == (mem_req_i.command != mshr_pkg::BUS_NONE)))
        else $error("memory command does not follow the grant");

    // Unaccepted request keeps grant and payload
    grant_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (grant_valid_i && (mem_resp_i.response == '0)) |=>
        (grant_valid_i && $stable(memory_grant_i) && $stable(mem_req_i)))
        else $error("grant or request changed before acceptance");

endmodule

bind mshr_memory_switch mshr_assertions mshr_assertions_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .grant_valid_i  (grant_valid),
    .req_i          (arbiter_req),
    .memory_grant_i (memory_grant_o),
    .mem_req_i      (mem_o),
    .mem_resp_i     (mem_i)
);

// File: mshr_entry.sv
`timescale 1ns/1ps
`include "mshr_params.svh"

module mshr_entry (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Allocation from the table
    input  logic                  alloc_i,
    input  mshr_pkg::miss_req_t   miss_i,
    // Memory side
    input  logic                  grant_i,
    input  mshr_pkg::mem_out_t    mem_i,
    // Fill side
    input  logic                  fill_taken_i,
    output logic                  busy_o,
    output logic                  done_o,
    output mshr_pkg::mem_in_t     request_o,
    output mshr_pkg::fill_t       fill_o
);

    mshr_pkg::mshr_state_e state_q;
    mshr_pkg::mshr_state_e state_d;

    // Payload of the miss being handled
    logic                  is_store_q;
    mshr_pkg::addr_t       addr_q;
    // Store data first, load data once returned
    mshr_pkg::data_t       line_q;
    mshr_pkg::mem_tag_t    tag_q;

    logic                  accepted;
    logic                  tag_hit;

    // Memory took our request this cycle
    assign accepted = (state_q == mshr_pkg::ST_REQ) && grant_i && (mem_i.response != '0);
    // Data return for our outstanding load
    assign tag_hit  = (state_q == mshr_pkg::ST_WAIT) && (mem_i.tag == tag_q);

    // ==========================================================
    // State machine
    // ==========================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            mshr_pkg::ST_IDLE: begin
                if (alloc_i) begin
                    state_d = mshr_pkg::ST_REQ;
                end
            end
            mshr_pkg::ST_REQ: begin
                // Stores retire at acceptance
                if (accepted) begin
                    state_d = is_store_q ? mshr_pkg::ST_DONE : mshr_pkg::ST_WAIT;
                end
            end
            mshr_pkg::ST_WAIT: begin
                if (tag_hit) begin
                    state_d = mshr_pkg::ST_DONE;
                end
            end
            mshr_pkg::ST_DONE: begin
                if (fill_taken_i) begin
                    state_d = mshr_pkg::ST_IDLE;
                end
            end
            default: state_d = mshr_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= mshr_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload capture
    always_ff @(posedge clk_i) begin
        if (alloc_i && (state_q == mshr_pkg::ST_IDLE)) begin
            is_store_q <= miss_i.is_store;
            addr_q     <= miss_i.addr;
            line_q     <= miss_i.data;
        end
        if (accepted) begin
            tag_q <= mem_i.response;
        end
        if (tag_hit) begin
            line_q <= mem_i.data;
        end
    end

    // ==========================================================
    // Outputs
    // ==========================================================
    always_comb begin
        // Command only while requesting
        request_o = '0;
        if (state_q == mshr_pkg::ST_REQ) begin
            request_o.command = is_store_q ? mshr_pkg::BUS_STORE : mshr_pkg::BUS_LOAD;
            request_o.addr    = addr_q;
            request_o.data    = line_q;
        end
    end

    assign fill_o.is_store = is_store_q;
    assign fill_o.addr     = addr_q;
    assign fill_o.data     = line_q;

    assign busy_o = (state_q != mshr_pkg::ST_IDLE);
    assign done_o = (state_q == mshr_pkg::ST_DONE);

endmodule

// File: mshr_memory_switch.sv
`timescale 1ns/1ps
`include "mshr_params.svh"

module mshr_memory_switch (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    // One request per entry
    input  mshr_pkg::mem_in_t [`MSHR_ENTRY_NUM-1:0] mshr_memory_i,
    // Shared memory response whose accept tag acknowledges the grant
    input  mshr_pkg::mem_out_t                      mem_i,
    output mshr_pkg::entry_vec_t                    memory_grant_o,
    output mshr_pkg::mem_in_t                       mem_o
);

    mshr_pkg::entry_vec_t arbiter_req;
    logic                 arbiter_ack;
    mshr_pkg::entry_idx_t grant_idx;
    logic                 grant_valid;

    // ==========================================================
    // Arbiter
    // ==========================================================
    mshr_rr_arbiter mshr_rr_arbiter_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (arbiter_req),
        .ack_i   (arbiter_ack),
        .grant_o (grant_idx),
        .valid_o (grant_valid)
    );

    // ==========================================================
    // Request collection and routing
    // ==========================================================
    always_comb begin
        // Load or store command marks a requester
        arbiter_req = '0;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            if ((mshr_memory_i[i].command == mshr_pkg::BUS_LOAD) ||
                (mshr_memory_i[i].command == mshr_pkg::BUS_STORE)) begin
                arbiter_req[i] = 1'b1;
            end
        end

        // Nonzero accept tag moves the arbiter on
        arbiter_ack = grant_valid && (mem_i.response != '0);

        // Granted request drives the memory port
        mem_o = '0;
        if (grant_valid) begin
            mem_o = mshr_memory_i[grant_idx];
        end

        // One-hot grant masked by valid
        memory_grant_o = '0;
        if (grant_valid) begin
            memory_grant_o[grant_idx] = 1'b1;
        end
    end

endmodule

// File: mshr_params.svh
`ifndef MSHR_PARAMS_SVH
`define MSHR_PARAMS_SVH

// ==========================================================
// MSHR sizing
// ==========================================================

// Number of MSHR entries
`define MSHR_ENTRY_NUM  4

// Miss address width
`define MSHR_ADDR_W     32

// Cache line width carried by memory and fills
`define MSHR_DATA_W     64

// Memory transaction tag width
// Tag 0 means not accepted
`define MSHR_TAG_W      4

`endif

// File: mshr_pkg.sv
`include "mshr_params.svh"

package mshr_pkg;

    // ==========================================================
    // Vector types
    // ==========================================================
    typedef logic [`MSHR_ADDR_W-1:0]            addr_t;
    typedef logic [`MSHR_DATA_W-1:0]            data_t;
    typedef logic [`MSHR_TAG_W-1:0]             mem_tag_t;
    typedef logic [$clog2(`MSHR_ENTRY_NUM)-1:0] entry_idx_t;
    // One bit per entry
    typedef logic [`MSHR_ENTRY_NUM-1:0]         entry_vec_t;

    // ==========================================================
    // Encodings
    // ==========================================================
    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } mem_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_WAIT = 2'd2,
        ST_DONE = 2'd3
    } mshr_state_e;

    // ==========================================================
    // Bundles
    // ==========================================================
    // Request toward memory
    typedef struct packed {
        mem_cmd_e command;
        addr_t    addr;
        data_t    data;
    } mem_in_t;

    // Accept tag plus data return
    typedef struct packed {
        mem_tag_t response;
        mem_tag_t tag;
        data_t    data;
    } mem_out_t;

    // Miss coming in from the cache
    typedef struct packed {
        logic  is_store;
        addr_t addr;
        data_t data;
    } miss_req_t;

    // Completion handed back to the cache
    typedef struct packed {
        logic  is_store;
        addr_t addr;
        data_t data;
    } fill_t;

endpackage

// File: mshr_rr_arbiter.sv
`timescale 1ns/1ps
`include "mshr_params.svh"

module mshr_rr_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  mshr_pkg::entry_vec_t   req_i,
    input  logic                   ack_i,
    output mshr_pkg::entry_idx_t   grant_o,
    output logic                   valid_o
);

    // Current holder doubles as the rotating priority pointer
    mshr_pkg::entry_idx_t grant_q;
    logic                 valid_q;

    mshr_pkg::entry_idx_t grant_d;
    logic                 valid_d;
    logic                 hold;
    // Requests still competing this cycle
    mshr_pkg::entry_vec_t req_masked;

    // ==========================================================
    // Next grant
    // ==========================================================
    always_comb begin
        mshr_pkg::entry_idx_t cand;
        cand = '0;
        // Holder keeps the grant until acknowledged
        hold = valid_q && req_i[grant_q] && !ack_i;

        // Acknowledged holder drops out of the search
        req_masked = req_i;
        if (ack_i && valid_q) begin
            req_masked[grant_q] = 1'b0;
        end

        // Search starts right after the last grant
        grant_d = grant_q;
        valid_d = 1'b0;
        for (int off = 1; off <= `MSHR_ENTRY_NUM; off++) begin
            cand = mshr_pkg::entry_idx_t'((int'(grant_q) + off) % `MSHR_ENTRY_NUM);
            if (!valid_d && req_masked[cand]) begin
                grant_d = cand;
                valid_d = 1'b1;
            end
        end

        if (hold) begin
            grant_d = grant_q;
            valid_d = 1'b1;
        end
    end

    // Registered grant
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grant_q <= '0;
            valid_q <= 1'b0;
        end else begin
            grant_q <= grant_d;
            valid_q <= valid_d;
        end
    end

    assign grant_o = grant_q;
    assign valid_o = valid_q;

endmodule

// File: mshr_table.sv
`timescale 1ns/1ps
`include "mshr_params.svh"

module mshr_table (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    // Miss port
    input  logic                                    miss_valid_i,
    input  mshr_pkg::miss_req_t                     miss_i,
    output logic                                    miss_ready_o,
    // One-hot memory grant from the switch
    input  mshr_pkg::entry_vec_t                    grant_i,
    input  mshr_pkg::mem_out_t                      mem_i,
    // Fill port
    input  logic                                    fill_ready_i,
    output logic                                    fill_valid_o,
    output mshr_pkg::fill_t                         fill_o,
    // Per-entry requests toward the switch
    output mshr_pkg::mem_in_t [`MSHR_ENTRY_NUM-1:0] requests_o
);

    mshr_pkg::entry_vec_t                      busy;
    mshr_pkg::entry_vec_t                      done;
    mshr_pkg::entry_vec_t                      alloc;
    mshr_pkg::entry_vec_t                      fill_taken;
    mshr_pkg::fill_t [`MSHR_ENTRY_NUM-1:0]     fills;

    mshr_pkg::entry_idx_t                      free_idx;
    mshr_pkg::entry_idx_t                      done_idx;

    // Lowest set bit of an entry vector
    function automatic mshr_pkg::entry_idx_t lowest_set(input mshr_pkg::entry_vec_t vec);
        mshr_pkg::entry_idx_t idx;
        idx = '0;
        for (int i = `MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = mshr_pkg::entry_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // ==========================================================
    // Allocation and fill selection
    // ==========================================================
    assign free_idx     = lowest_set(~busy);
    assign miss_ready_o = ~&busy;

    assign done_idx     = lowest_set(done);
    assign fill_valid_o = |done;
    assign fill_o       = fills[done_idx];

    always_comb begin
        alloc      = '0;
        fill_taken = '0;
        // New miss lands in the lowest free slot
        if (miss_valid_i && miss_ready_o) begin
            alloc[free_idx] = 1'b1;
        end
        // Only the presented entry retires
        if (fill_valid_o && fill_ready_i) begin
            fill_taken[done_idx] = 1'b1;
        end
    end

    // ==========================================================
    // Entries
    // ==========================================================
    for (genvar i = 0; i < `MSHR_ENTRY_NUM; i++) begin : g_entry
        mshr_entry mshr_entry_inst (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .alloc_i      (alloc[i]),
            .miss_i       (miss_i),
            .grant_i      (grant_i[i]),
            .mem_i        (mem_i),
            .fill_taken_i (fill_taken[i]),
            .busy_o       (busy[i]),
            .done_o       (done[i]),
            .request_o    (requests_o[i]),
            .fill_o       (fills[i])
        );
    end

endmodule

// File: mshr_tb.sv
`timescale 1ns/1ps
`include "mshr_params.svh"

module mshr_tb;

    localparam int CLK_PERIOD      = 4;
    localparam int MISS_TOTAL      = 400;
    localparam int CYCLES_PER_MISS = 40;
    localparam int WATCHDOG_NS     = CLK_PERIOD * MISS_TOTAL * CYCLES_PER_MISS;
    localparam int SLOTS           = 8;
    localparam int ADDR_BASE       = 32'h0000_1000;
    localparam int SEQ_MAX         = 1024;
    localparam int TAG_NUM         = 1 << `MSHR_TAG_W;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    miss_valid_i;
    mshr_pkg::miss_req_t     miss_i;
    logic                    miss_ready_o;
    logic                    fill_valid_o;
    mshr_pkg::fill_t         fill_o;
    logic                    fill_ready_i;
    mshr_pkg::mem_in_t       mem_o;
    mshr_pkg::mem_out_t      mem_i;

    // ==========================================================
    // Model state
    // ==========================================================
    integer                  seed;
    int                      error_count;
    int                      check_count;
    // One memory line per slot
    mshr_pkg::data_t         mem_model [SLOTS];
    // Expected fills per slot in acceptance order
    mshr_pkg::fill_t         exp_q [SLOTS][$];
    // Tags handed out for loads still waiting on data
    logic                    tag_busy  [TAG_NUM];
    int                      tag_delay [TAG_NUM];
    mshr_pkg::data_t         tag_data  [TAG_NUM];
    int                      ret_tag;
    // Acceptance count at the time each miss was taken
    int                      take_mark [SEQ_MAX];
    // Each taken miss by sequence number
    mshr_pkg::miss_req_t     miss_log [SEQ_MAX];
    // 0 not taken, 1 taken, 2 accepted by memory
    int                      miss_stage [SEQ_MAX];
    int                      accept_count;
    int                      taken_count;
    int                      fill_count;
    int                      gen_count;
    logic                    miss_taken_last;
    logic                    prev_cmd_valid;
    logic                    prev_accepted;
    mshr_pkg::mem_in_t       prev_mem;
    // Stimulus knobs
    logic                    gen_enable;
    logic                    stall;
    int                      valid_pct;
    int                      fill_pct;

    mshr_top mshr_top_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .miss_valid_i (miss_valid_i),
        .miss_i       (miss_i),
        .miss_ready_o (miss_ready_o),
        .fill_valid_o (fill_valid_o),
        .fill_o       (fill_o),
        .fill_ready_i (fill_ready_i),
        .mem_o        (mem_o),
        .mem_i        (mem_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ==========================================================
    // Helpers
    // ==========================================================
    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    // True with the given percentage
    function automatic logic roll(input int pct);
        int r;
        r = int'($unsigned($random(seed)) % 32'd100);
        return r < pct;
    endfunction

    function automatic mshr_pkg::addr_t addr_of(input int slot);
        return mshr_pkg::addr_t'(ADDR_BASE + slot * 8);
    endfunction

    // Slot of an address or -1 outside the missed range
    function automatic int slot_of(input mshr_pkg::addr_t a);
        mshr_pkg::addr_t off;
        off = a - mshr_pkg::addr_t'(ADDR_BASE);
        if ((a < mshr_pkg::addr_t'(ADDR_BASE)) || (off >= 32'd64) || (a[2:0] != 3'd0)) begin
            return -1;
        end
        return int'(off >> 3);
    endfunction

    // Initial line contents depend on the whole address
    function automatic mshr_pkg::data_t initial_line(input mshr_pkg::addr_t a);
        return {a ^ 32'h5A5A_A5A5, ~a};
    endfunction

    // ==========================================================
    // One cycle at the falling edge
    // ==========================================================
    // Registered outputs settle early and fix the handshakes of the next edge
    task automatic step();
        mshr_pkg::fill_t     got;
        mshr_pkg::fill_t     exp;
        mshr_pkg::miss_req_t rec;
        mshr_pkg::mem_in_t   req_exp;
        int                  slot;
        int                  found;
        int                  t;
        int                  cand;
        int                  start;
        int                  waited;
        int                  seqn;
        logic                accept;
        check_value("miss_ready_o", 128'(miss_ready_o),
                    128'((taken_count - fill_count) < `MSHR_ENTRY_NUM));
        if (taken_count == fill_count) begin
            check_value("fill_valid_o", 128'(fill_valid_o), 128'(1'b0));
        end
        // Unaccepted request must stay put
        if (prev_cmd_valid && !prev_accepted) begin
            check_value("mem_o", 128'(mem_o), 128'(prev_mem));
        end

        // Miss stays on the port until taken
        if (!miss_valid_i || miss_taken_last) begin
            miss_valid_i = 1'b0;
            if (gen_enable && roll(valid_pct)) begin
                miss_valid_i      = 1'b1;
                miss_i.is_store   = roll(40);
                miss_i.addr       = addr_of(int'($unsigned($random(seed)) % 32'd8));
                miss_i.data       = {$random(seed), 32'(gen_count)};
                gen_count++;
            end
        end
        fill_ready_i = roll(fill_pct);

        // Data returns
        if (ret_tag != 0) begin
            tag_busy[ret_tag] = 1'b0;
        end
        ret_tag = 0;
        for (int i = 1; i < TAG_NUM; i++) begin
            if (tag_busy[i] && (tag_delay[i] > 0)) begin
                tag_delay[i]--;
            end
        end
        for (int i = 1; i < TAG_NUM; i++) begin
            if ((ret_tag == 0) && tag_busy[i] && (tag_delay[i] == 0)) begin
                ret_tag = i;
            end
        end
        mem_i.tag  = mshr_pkg::mem_tag_t'(ret_tag);
        mem_i.data = (ret_tag != 0) ? tag_data[ret_tag] : {$random(seed), $random(seed)};

        // Acceptance with a free nonzero tag
        t = 0;
        if ((mem_o.command != mshr_pkg::BUS_NONE) && !stall && roll(50)) begin
            start = int'($unsigned($random(seed)) % 32'(TAG_NUM - 1));
            for (int i = 0; i < TAG_NUM - 1; i++) begin
                cand = 1 + ((start + i) % (TAG_NUM - 1));
                if ((t == 0) && !tag_busy[cand]) begin
                    t = cand;
                end
            end
        end
        accept         = (t != 0);
        mem_i.response = mshr_pkg::mem_tag_t'(t);

        if (accept) begin
            accept_count++;
            seqn = int'(mem_o.data[31:0]);
            if ((seqn < 0) || (seqn >= SEQ_MAX) || (miss_stage[seqn] != 1)) begin
                report_failure("memory request does not belong to a waiting miss");
            end else begin
                miss_stage[seqn] = 2;
                rec              = miss_log[seqn];
                // Request rebuilt from the miss that was sent
                req_exp.command  = rec.is_store ? mshr_pkg::BUS_STORE : mshr_pkg::BUS_LOAD;
                req_exp.addr     = rec.addr;
                req_exp.data     = rec.data;
                check_value("mem_o", 128'(mem_o), 128'(req_exp));
                waited = accept_count - take_mark[seqn];
                if (waited > `MSHR_ENTRY_NUM) begin
                    report_failure($sformatf("miss %0d waited %0d acceptances", seqn, waited));
                end
                slot         = slot_of(rec.addr);
                exp.is_store = rec.is_store;
                exp.addr     = rec.addr;
                if (rec.is_store) begin
                    // Store lands in memory at acceptance
                    mem_model[slot] = rec.data;
                end else begin
                    tag_busy[t]  = 1'b1;
                    tag_delay[t] = 1 + int'($unsigned($random(seed)) % 32'd6);
                    tag_data[t]  = mem_model[slot];
                end
                exp.data = mem_model[slot];
                exp_q[slot].push_back(exp);
            end
        end
        prev_cmd_valid = (mem_o.command != mshr_pkg::BUS_NONE);
        prev_accepted  = accept;
        prev_mem       = mem_o;

        // Fill hand-off checked against the scoreboard
        if (fill_valid_o && fill_ready_i) begin
            fill_count++;
            got  = fill_o;
            slot = slot_of(got.addr);
            if (slot < 0) begin
                report_failure("fill carries an address that was never missed");
            end else begin
                found = -1;
                for (int i = 0; i < exp_q[slot].size(); i++) begin
                    if ((found < 0) && (exp_q[slot][i] == got)) begin
                        found = i;
                    end
                end
                if (found >= 0) begin
                    exp_q[slot].delete(found);
                end else if (exp_q[slot].size() == 0) begin
                    report_failure("fill with no accepted request behind it");
                end else begin
                    check_value("fill_o", 128'(got), 128'(exp_q[slot][0]));
                end
            end
        end

        // Miss taken at the coming edge
        miss_taken_last = miss_valid_i && miss_ready_o;
        if (miss_taken_last) begin
            seqn = int'(miss_i.data[31:0]);
            take_mark[seqn]  = accept_count;
            miss_log[seqn]   = miss_i;
            miss_stage[seqn] = 1;
            taken_count++;
        end
    endtask

    task automatic run_until_taken(input int target);
        while (taken_count < target) begin
            @(negedge clk_i);
            step();
        end
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        seed            = 32'h2823;
        error_count     = 0;
        check_count     = 0;
        accept_count    = 0;
        taken_count     = 0;
        fill_count      = 0;
        gen_count       = 0;
        ret_tag         = 0;
        miss_taken_last = 1'b0;
        prev_cmd_valid  = 1'b0;
        prev_accepted   = 1'b0;
        prev_mem        = '0;
        gen_enable      = 1'b0;
        stall           = 1'b0;
        valid_pct       = 0;
        fill_pct        = 0;
        for (int i = 0; i < SLOTS; i++) begin
            mem_model[i] = initial_line(addr_of(i));
        end
        for (int i = 0; i < TAG_NUM; i++) begin
            tag_busy[i]  = 1'b0;
            tag_delay[i] = 0;
            tag_data[i]  = '0;
        end
        for (int i = 0; i < SEQ_MAX; i++) begin
            take_mark[i]  = 0;
            miss_log[i]   = '0;
            miss_stage[i] = 0;
        end
        rst_n_i      = 1'b0;
        miss_valid_i = 1'b0;
        miss_i       = '0;
        fill_ready_i = 1'b0;
        mem_i        = '0;

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_value("miss_ready_o", 128'(miss_ready_o), 128'(1'b1));
        check_value("fill_valid_o", 128'(fill_valid_o), 128'(1'b0));
        check_value("mem_o.command", 128'(mem_o.command), 128'(mshr_pkg::BUS_NONE));

        // Mixed random traffic
        gen_enable = 1'b1;
        valid_pct  = 70;
        fill_pct   = 70;
        run_until_taken(100);

        // Stalled memory lets the table fill up
        stall     = 1'b1;
        valid_pct = 100;
        fill_pct  = 100;
        repeat (30) begin
            @(negedge clk_i);
            step();
        end
        @(negedge clk_i);
        check_value("miss_ready_o", 128'(miss_ready_o), 128'(1'b0));
        if ((taken_count - fill_count) != `MSHR_ENTRY_NUM) begin
            report_failure("table not full after the memory stall");
        end
        stall = 1'b0;
        step();

        // Fill back-pressure
        valid_pct = 80;
        fill_pct  = 25;
        run_until_taken(250);

        // Every entry competing for memory
        valid_pct = 100;
        fill_pct  = 100;
        run_until_taken(MISS_TOTAL);

        // Drain
        gen_enable = 1'b0;
        while ((taken_count != fill_count) || miss_valid_i) begin
            @(negedge clk_i);
            step();
        end

        for (int i = 0; i < SLOTS; i++) begin
            if (exp_q[i].size() != 0) begin
                report_failure($sformatf("%0d expected fills never seen at slot %0d",
                                         exp_q[i].size(), i));
            end
        end

        $display("Errors: %0d, checks: %0d, misses: %0d, fills: %0d",
                 error_count, check_count, taken_count, fill_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the miss count
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors: %0d, checks: %0d, misses: %0d, fills: %0d",
                 error_count, check_count, taken_count, fill_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: mshr_top.f
+incdir+.
mshr_pkg.sv
mshr_rr_arbiter.sv
mshr_memory_switch.sv
mshr_entry.sv
mshr_table.sv
mshr_top.sv
mshr_assertions.sv
mshr_tb.sv

// File: mshr_top.sv
`timescale 1ns/1ps
`include "mshr_params.svh"

module mshr_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Misses from the cache
    input  logic                  miss_valid_i,
    input  mshr_pkg::miss_req_t   miss_i,
    output logic                  miss_ready_o,
    // Fills back to the cache
    output logic                  fill_valid_o,
    output mshr_pkg::fill_t       fill_o,
    input  logic                  fill_ready_i,
    // Shared memory port
    output mshr_pkg::mem_in_t     mem_o,
    input  mshr_pkg::mem_out_t    mem_i
);

    // Entry requests and returned grant
    mshr_pkg::mem_in_t [`MSHR_ENTRY_NUM-1:0] requests;
    mshr_pkg::entry_vec_t                    memory_grant;

    mshr_table mshr_table_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .miss_valid_i (miss_valid_i),
        .miss_i       (miss_i),
        .miss_ready_o (miss_ready_o),
        .grant_i      (memory_grant),
        .mem_i        (mem_i),
        .fill_ready_i (fill_ready_i),
        .fill_valid_o (fill_valid_o),
        .fill_o       (fill_o),
        .requests_o   (requests)
    );

    mshr_memory_switch mshr_memory_switch_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mshr_memory_i  (requests),
        .mem_i          (mem_i),
        .memory_grant_o (memory_grant),
        .mem_o          (mem_o)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the MSHR testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f mshr_top.f --top-module mshr_tb

# Status of the pipeline is the status of grep
./obj_dir/Vmshr_tb | tee /dev/stderr | grep -F "Simulation completed successfully" > /dev/null

echo "run_sim.sh: PASS"
